/* hdl/pulse_sym_pkg.sv */
/*
 * Pulse transmitter symbol package
 * Symbol code, output level, duration and the records passed
 * between the sequencer, decode and timer stages
 */
package pulse_sym_pkg;

    // Bit 1 is the level, bit 0 picks duration a or b
    typedef logic [1:0] sym_code_t;
    typedef logic       level_t;
    typedef logic [7:0] duration_t;

    // Sequencer to decode
    typedef struct packed {
        sym_code_t code;
        logic      last;
    } sym_req_t;

    // Decode to timer
    typedef struct packed {
        level_t    level;
        duration_t duration;
        logic      last;
    } sym_beat_t;

    typedef enum logic {
        IDLE,
        RUN
    } timer_state_t;

endpackage

/* hdl/pulse_cfg_pkg.sv */
/*
 * Pulse transmitter configuration package
 * Register map, field types and the configuration record that the
 * register bank hands to every pipeline stage
 */
package pulse_cfg_pkg;

    typedef logic [5:0]  addr_t;
    typedef logic [31:0] word_t;
    // Bits 6..4 pick the program word, bits 3..0 the symbol in it
    typedef logic [6:0]  sym_index_t;
    typedef logic [7:0]  loop_count_t;
    typedef logic [3:0]  prescale_t;
    // Bit 0 loop flag, bit 1 end flag
    typedef logic [1:0]  irq_vec_t;

    localparam int unsigned NUM_PROG_WORDS = 8;
    localparam int unsigned SYMS_PER_WORD  = 16;
    localparam int unsigned PROG_SEL_W     = $clog2(NUM_PROG_WORDS);
    localparam int unsigned SYM_SEL_W      = $clog2(SYMS_PER_WORD);

    localparam int unsigned REG_CTRL_ADDR  = 0;
    localparam int unsigned REG_PROG_ADDR  = 4;
    localparam int unsigned REG_DUR_ADDR   = 8;
    localparam int unsigned REG_PRESC_ADDR = 12;
    localparam int unsigned PROG_MEM_BASE  = 32;

    localparam int unsigned CTRL_START_BIT = 4;
    localparam int unsigned CTRL_STOP_BIT  = 5;

    // Durations are indexed by symbol code, code 0 in the low byte
    typedef struct packed {
        irq_vec_t                           irq_enable;
        logic                               loop_forever;
        logic                               idle_level;
        logic                               invert;
        logic                               downcount;
        sym_index_t                         start_index;
        sym_index_t                         end_index;
        sym_index_t                         loopback_index;
        loop_count_t                        loop_count;
        pulse_sym_pkg::duration_t [3:0]     durations;
        prescale_t                          prescaler;
    } cfg_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } bus_req_t;

endpackage

/* hdl/pulse_regs.sv */
/*
 * Pulse transmitter register bank
 * Configuration registers, eight-word program memory, run control,
 * sticky interrupt flags and the status readback word
 */
module pulse_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  pulse_cfg_pkg::bus_req_t    bus,
    output pulse_cfg_pkg::word_t       rdata,
    output pulse_cfg_pkg::cfg_t        cfg,
    output logic                       running,
    input  pulse_cfg_pkg::sym_index_t  read_index,
    output pulse_cfg_pkg::word_t       prog_word,
    input  pulse_cfg_pkg::sym_index_t  cur_index,
    input  pulse_cfg_pkg::loop_count_t loop_left,
    input  logic                       loop_event,
    input  logic                       done,
    output logic                       irq
);

    pulse_cfg_pkg::cfg_t     cfg_q;
    pulse_cfg_pkg::irq_vec_t flags_q;
    pulse_cfg_pkg::irq_vec_t flag_set;
    pulse_cfg_pkg::irq_vec_t flag_clr;
    pulse_cfg_pkg::word_t    prog_mem [pulse_cfg_pkg::NUM_PROG_WORDS];
    logic                    running_q;
    logic                    start_req_q;
    logic                    ctrl_wr;
    logic                    idx_wr;
    logic                    dur_wr;
    logic                    presc_wr;
    logic                    mem_wr;

    // Address decode, only full 32-bit writes exist
    assign ctrl_wr  = bus.write && (bus.addr == pulse_cfg_pkg::addr_t'(pulse_cfg_pkg::REG_CTRL_ADDR));
    assign idx_wr   = bus.write && (bus.addr == pulse_cfg_pkg::addr_t'(pulse_cfg_pkg::REG_PROG_ADDR));
    assign dur_wr   = bus.write && (bus.addr == pulse_cfg_pkg::addr_t'(pulse_cfg_pkg::REG_DUR_ADDR));
    assign presc_wr = bus.write && (bus.addr == pulse_cfg_pkg::addr_t'(pulse_cfg_pkg::REG_PRESC_ADDR));
    assign mem_wr   = bus.write && (bus.addr >= pulse_cfg_pkg::addr_t'(pulse_cfg_pkg::PROG_MEM_BASE));

    // Bit 0 loop, bit 1 end
    assign flag_set = {done, loop_event};
    assign flag_clr = ctrl_wr ? bus.wdata[1:0] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q       <= '0;
            flags_q     <= '0;
            running_q   <= 1'b0;
            start_req_q <= 1'b0;
        end else begin
            // Start only from idle, and stop wins over start
            start_req_q <= ctrl_wr && bus.wdata[pulse_cfg_pkg::CTRL_START_BIT]
                           && !bus.wdata[pulse_cfg_pkg::CTRL_STOP_BIT]
                           && !running_q && !start_req_q;
            flags_q <= (flags_q & ~flag_clr) | (flag_set & cfg_q.irq_enable);
            if (ctrl_wr && bus.wdata[pulse_cfg_pkg::CTRL_STOP_BIT]) begin
                running_q <= 1'b0;
            end else if (done) begin
                running_q <= 1'b0;
            end else if (start_req_q) begin
                running_q <= 1'b1;
            end
            if (ctrl_wr) begin
                cfg_q.irq_enable   <= bus.wdata[9:8];
                cfg_q.loop_forever <= bus.wdata[12];
                cfg_q.idle_level   <= bus.wdata[13];
                cfg_q.invert       <= bus.wdata[14];
                cfg_q.downcount    <= bus.wdata[16];
            end
            if (idx_wr) begin
                cfg_q.start_index    <= bus.wdata[6:0];
                cfg_q.end_index      <= bus.wdata[14:8];
                cfg_q.loopback_index <= bus.wdata[22:16];
                cfg_q.loop_count     <= bus.wdata[31:24];
            end
            if (dur_wr) begin
                cfg_q.durations <= bus.wdata;
            end
            if (presc_wr) begin
                cfg_q.prescaler <= bus.wdata[31:28];
            end
        end
    end

    // Program words at 32, 36, ... 60
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            prog_mem[bus.addr[2 +: pulse_cfg_pkg::PROG_SEL_W]] <= bus.wdata;
        end
    end

    assign prog_word = prog_mem[read_index[pulse_cfg_pkg::SYM_SEL_W +: pulse_cfg_pkg::PROG_SEL_W]];
    assign cfg       = cfg_q;
    assign running   = running_q;
    assign irq       = |flags_q;

    // Status readback, the address is not decoded
    assign rdata = {8'h00, loop_left, 1'b0, cur_index, 3'b000, running_q, 2'b00, flags_q};

endmodule

/* hdl/pulse_sequencer.sv */
/*
 * Pulse transmitter sequencer
 * Walks the symbol index from start to end, up or down, loops back
 * a set number of times and issues one symbol request per step
 */
module pulse_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  pulse_cfg_pkg::cfg_t        cfg,
    input  logic                       running,
    input  pulse_cfg_pkg::word_t       prog_word,
    output pulse_cfg_pkg::sym_index_t  read_index,
    output pulse_sym_pkg::sym_req_t    req,
    output logic                       req_valid,
    input  logic                       req_ready,
    output logic                       loop_event,
    output pulse_cfg_pkg::loop_count_t loop_left
);

    pulse_cfg_pkg::sym_index_t  index_q;
    pulse_cfg_pkg::sym_index_t  next_index;
    pulse_cfg_pkg::loop_count_t loop_q;
    logic                       finished_q;
    logic                       at_end;
    logic                       do_loop;
    logic                       xfer;

    // Program word comes back combinationally from the register bank
    assign read_index = index_q;

    assign at_end  = (index_q == cfg.end_index);
    assign do_loop = at_end && (cfg.loop_forever || (loop_q != '0));

    // Step by one symbol, the 7-bit index wraps through 0
    assign next_index = cfg.downcount ? index_q - pulse_cfg_pkg::sym_index_t'(1)
                                      : index_q + pulse_cfg_pkg::sym_index_t'(1);

    // Symbol select within the word
    assign req.code = prog_word[index_q[pulse_cfg_pkg::SYM_SEL_W-1:0]
                                * $bits(pulse_sym_pkg::sym_code_t)
                                +: $bits(pulse_sym_pkg::sym_code_t)];
    assign req.last = at_end && !do_loop;

    // Stop issuing once the last request has gone
    assign req_valid  = running && !finished_q;
    assign xfer       = req_valid && req_ready;
    assign loop_event = xfer && do_loop;
    assign loop_left  = loop_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index_q    <= '0;
            loop_q     <= '0;
            finished_q <= 1'b0;
        end else if (!running) begin
            // Flushed, hold the start values
            index_q    <= cfg.start_index;
            loop_q     <= cfg.loop_count;
            finished_q <= 1'b0;
        end else if (xfer) begin
            if (!at_end) begin
                index_q <= next_index;
            end else if (do_loop) begin
                index_q <= cfg.loopback_index;
                loop_q  <= loop_q - pulse_cfg_pkg::loop_count_t'(1);
            end else begin
                finished_q <= 1'b1;
            end
        end
    end

endmodule

/* hdl/pulse_symbol_decode.sv */
/*
 * Pulse transmitter symbol decode
 * One-entry register slot mapping a symbol code to level and duration
 */
module pulse_symbol_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pulse_cfg_pkg::cfg_t      cfg,
    input  logic                     running,
    input  pulse_sym_pkg::sym_req_t  req,
    input  logic                     req_valid,
    output logic                     req_ready,
    output pulse_sym_pkg::sym_beat_t beat,
    output logic                     beat_valid,
    input  logic                     beat_ready
);

    pulse_sym_pkg::sym_beat_t beat_q;
    logic                     full_q;
    logic                     take;

    // Refill in the same cycle the held beat leaves
    assign req_ready = !full_q || beat_ready;
    assign take      = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (!running) begin
            full_q <= 1'b0;
        end else if (take) begin
            full_q <= 1'b1;
        end else if (beat_ready) begin
            full_q <= 1'b0;
        end
    end

    // Level from code bit 1, duration looked up by the whole code
    always_ff @(posedge clk) begin
        if (take) begin
            beat_q.level    <= req.code[1];
            beat_q.duration <= cfg.durations[req.code];
            beat_q.last     <= req.last;
        end
    end

    assign beat       = beat_q;
    assign beat_valid = full_q;

endmodule

/* hdl/pulse_timer.sv */
/*
 * Pulse transmitter symbol timer
 * Holds each beat level for (duration+1) prescaled ticks and drives
 * the output pin with idle level and inversion
 */
module pulse_timer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pulse_cfg_pkg::cfg_t      cfg,
    input  logic                     running,
    input  pulse_sym_pkg::sym_beat_t beat,
    input  logic                     beat_valid,
    output logic                     beat_ready,
    output pulse_sym_pkg::level_t    tx,
    output logic                     tx_active,
    output logic                     done
);

    pulse_sym_pkg::timer_state_t state_q;
    pulse_sym_pkg::duration_t    dur_cnt;
    pulse_sym_pkg::level_t       level_q;
    logic [14:0]                 presc_cnt;
    logic [14:0]                 presc_max;
    logic                        last_q;
    logic                        done_q;
    logic                        tick;
    logic                        final_cycle;

    // One tick every 2^prescaler cycles
    assign presc_max   = (15'd1 << cfg.prescaler) - 15'd1;
    assign tick        = (presc_cnt == presc_max);
    assign final_cycle = (state_q == pulse_sym_pkg::RUN) && tick && (dur_cnt == '0);

    // Ready while idle and in the final cycle of a symbol
    assign beat_ready = (state_q == pulse_sym_pkg::IDLE) || final_cycle;

    always_ff @(posedge clk) begin
        if (!rst_n || !running) begin
            state_q   <= pulse_sym_pkg::IDLE;
            presc_cnt <= '0;
            dur_cnt   <= '0;
            level_q   <= 1'b0;
            last_q    <= 1'b0;
        end else if (beat_valid && beat_ready) begin
            // Back to back load, no gap between symbols
            state_q   <= pulse_sym_pkg::RUN;
            presc_cnt <= '0;
            dur_cnt   <= beat.duration;
            level_q   <= beat.level;
            last_q    <= beat.last;
        end else if (final_cycle) begin
            state_q <= pulse_sym_pkg::IDLE;
        end else if (state_q == pulse_sym_pkg::RUN) begin
            if (tick) begin
                presc_cnt <= '0;
                dur_cnt   <= dur_cnt - pulse_sym_pkg::duration_t'(1);
            end else begin
                presc_cnt <= presc_cnt + 15'd1;
            end
        end
    end

    // Done one cycle after the last beat ends
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= running && final_cycle && last_q;
        end
    end

    // Running low drops the pin to idle without waiting a cycle
    assign tx_active = (state_q == pulse_sym_pkg::RUN) && running;
    assign tx        = (tx_active ? level_q : cfg.idle_level) ^ cfg.invert;
    assign done      = done_q;

endmodule

/* hdl/pulse_transmitter.sv */
/*
 * Programmable pulse-train transmitter
 * Register bank feeding a sequencer, decode and timer pipeline
 */
module pulse_transmitter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pulse_cfg_pkg::bus_req_t bus,
    output pulse_cfg_pkg::word_t    rdata,
    output pulse_sym_pkg::level_t   tx,
    output logic                    tx_active,
    output logic                    irq
);

    pulse_cfg_pkg::cfg_t        cfg;
    pulse_cfg_pkg::word_t       prog_word;
    pulse_cfg_pkg::sym_index_t  read_index;
    pulse_cfg_pkg::loop_count_t loop_left;
    pulse_sym_pkg::sym_req_t    req;
    pulse_sym_pkg::sym_beat_t   beat;
    logic                       running;
    logic                       req_valid;
    logic                       req_ready;
    logic                       beat_valid;
    logic                       beat_ready;
    logic                       loop_event;
    logic                       done;

    // Fetch index doubles as the status index
    pulse_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus),
        .rdata      (rdata),
        .cfg        (cfg),
        .running    (running),
        .read_index (read_index),
        .prog_word  (prog_word),
        .cur_index  (read_index),
        .loop_left  (loop_left),
        .loop_event (loop_event),
        .done       (done),
        .irq        (irq)
    );

    pulse_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .running    (running),
        .prog_word  (prog_word),
        .read_index (read_index),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .loop_event (loop_event),
        .loop_left  (loop_left)
    );

    pulse_symbol_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .running    (running),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready)
    );

    pulse_timer u_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .running    (running),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .tx         (tx),
        .tx_active  (tx_active),
        .done       (done)
    );

endmodule

/* tb/clk_gen.sv */
/*
 * Testbench clock and reset
 * 40 ns clock, synchronous active-low reset held for 16 cycles
 */
module clk_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Release just after a rising edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

/* tb/tb_pulse_transmitter.sv */
/*
 * Pulse transmitter testbench
 * Table of programs run through the DUT, tx checked every cycle
 * against a model of the index rules, then status and flags
 */
module tb_pulse_transmitter;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned NUM_ROWS   = 6;
    localparam int unsigned ROW_MARGIN = 64;

    typedef struct {
        pulse_cfg_pkg::cfg_t     cfg;
        pulse_cfg_pkg::word_t    prog [pulse_cfg_pkg::NUM_PROG_WORDS];
        int unsigned             stop_after;
        pulse_cfg_pkg::irq_vec_t exp_flags;
    } row_t;

    logic                    clk;
    logic                    rst_n;
    pulse_cfg_pkg::bus_req_t bus;
    pulse_cfg_pkg::word_t    rdata;
    pulse_sym_pkg::level_t   tx;
    logic                    tx_active;
    logic                    irq;

    row_t                    rows [NUM_ROWS];
    pulse_sym_pkg::level_t   exp_tx [$];
    int unsigned             cycle_count;
    int unsigned             cycle_limit;
    int unsigned             error_count;
    int unsigned             seed_value;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pulse_transmitter UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .rdata     (rdata),
        .tx        (tx),
        .tx_active (tx_active),
        .irq       (irq)
    );

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    // Cycle budget against a limit worked out from the table
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic check_level(input pulse_sym_pkg::level_t got, input pulse_sym_pkg::level_t exp,
                               input string what);
        if (got !== exp) begin
            error_count++;
            $display("ERR %0d ns: %s is %0b, expected %0b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_index(input pulse_cfg_pkg::sym_index_t got,
                               input pulse_cfg_pkg::sym_index_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("ERR %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_loop(input pulse_cfg_pkg::loop_count_t got,
                              input pulse_cfg_pkg::loop_count_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("ERR %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flags(input pulse_cfg_pkg::irq_vec_t got,
                               input pulse_cfg_pkg::irq_vec_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("ERR %0d ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Single control bits such as running, tx_active and irq
    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("ERR %0d ns: %s is %0b, expected %0b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Sample and drive point 2 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_reg(input int unsigned addr, input pulse_cfg_pkg::word_t data);
        bus.write = 1'b1;
        bus.addr  = pulse_cfg_pkg::addr_t'(addr);
        bus.wdata = data;
        step_cycle();
        bus.write = 1'b0;
    endtask

    // Control word fields as laid out in the register map
    function automatic pulse_cfg_pkg::word_t ctrl_word(input pulse_cfg_pkg::cfg_t c);
        pulse_cfg_pkg::word_t w;
        w      = '0;
        w[9:8] = c.irq_enable;
        w[12]  = c.loop_forever;
        w[13]  = c.idle_level;
        w[14]  = c.invert;
        w[16]  = c.downcount;
        return w;
    endfunction

    function automatic row_t make_row(
        input pulse_cfg_pkg::sym_index_t start_i, input pulse_cfg_pkg::sym_index_t end_i,
        input pulse_cfg_pkg::sym_index_t back_i, input pulse_cfg_pkg::loop_count_t loops,
        input logic loop_all, input logic down, input logic idle, input logic inv,
        input pulse_cfg_pkg::irq_vec_t irq_en, input pulse_cfg_pkg::word_t durs,
        input pulse_cfg_pkg::prescale_t presc, input int unsigned stop_after,
        input pulse_cfg_pkg::irq_vec_t exp_flags);
        row_t r;
        r.cfg                = '0;
        r.cfg.start_index    = start_i;
        r.cfg.end_index      = end_i;
        r.cfg.loopback_index = back_i;
        r.cfg.loop_count     = loops;
        r.cfg.loop_forever   = loop_all;
        r.cfg.downcount      = down;
        r.cfg.idle_level     = idle;
        r.cfg.invert         = inv;
        r.cfg.irq_enable     = irq_en;
        r.cfg.durations      = durs;
        r.cfg.prescaler      = presc;
        r.stop_after         = stop_after;
        r.exp_flags          = exp_flags;
        // Random program of sixteen 2-bit codes per word
        for (int w = 0; w < pulse_cfg_pkg::NUM_PROG_WORDS; w++) begin
            r.prog[w] = $urandom();
        end
        return r;
    endfunction

    // Model of the index walk giving one expected tx value per cycle
    task automatic build_expected(input row_t r, output pulse_cfg_pkg::loop_count_t loops_end);
        pulse_cfg_pkg::sym_index_t   idx;
        pulse_cfg_pkg::loop_count_t  loops;
        pulse_sym_pkg::sym_code_t    code;
        int unsigned                 width;
        bit                          more;
        exp_tx.delete();
        idx   = r.cfg.start_index;
        loops = r.cfg.loop_count;
        more  = 1'b1;
        while (more) begin
            code  = r.prog[idx[6:4]][idx[3:0] * 2 +: 2];
            width = (int'(r.cfg.durations[code]) + 1) << r.cfg.prescaler;
            repeat (width) exp_tx.push_back(code[1] ^ r.cfg.invert);
            if (r.stop_after != 0 && exp_tx.size() >= r.stop_after) begin
                more = 1'b0;
            end else if (idx != r.cfg.end_index) begin
                idx = r.cfg.downcount ? idx - 7'd1 : idx + 7'd1;
            end else if (r.cfg.loop_forever || loops != 0) begin
                idx   = r.cfg.loopback_index;
                loops = loops - 8'd1;
            end else begin
                more = 1'b0;
            end
        end
        // A stopped program ends mid symbol
        while (r.stop_after != 0 && exp_tx.size() > r.stop_after) exp_tx.pop_back();
        loops_end = loops;
    endtask

    task automatic run_row(input int unsigned i);
        row_t                       r;
        pulse_cfg_pkg::loop_count_t loops_end;
        pulse_sym_pkg::level_t      idle_tx;
        pulse_cfg_pkg::word_t       idx_word;
        r        = rows[i];
        idle_tx  = r.cfg.idle_level ^ r.cfg.invert;
        idx_word = {r.cfg.loop_count, 1'b0, r.cfg.loopback_index, 1'b0, r.cfg.end_index,
                    1'b0, r.cfg.start_index};
        build_expected(r, loops_end);
        write_reg(pulse_cfg_pkg::REG_PROG_ADDR, idx_word);
        write_reg(pulse_cfg_pkg::REG_DUR_ADDR, r.cfg.durations);
        write_reg(pulse_cfg_pkg::REG_PRESC_ADDR, {r.cfg.prescaler, 28'h0});
        for (int w = 0; w < pulse_cfg_pkg::NUM_PROG_WORDS; w++) begin
            write_reg(pulse_cfg_pkg::PROG_MEM_BASE + 4 * w, r.prog[w]);
        end
        // Clear old flags and start in one write
        write_reg(pulse_cfg_pkg::REG_CTRL_ADDR,
                  ctrl_word(r.cfg) | (32'd1 << pulse_cfg_pkg::CTRL_START_BIT) | 32'd3);
        while (!tx_active) begin
            check_level(tx, idle_tx, "idle tx before start");
            step_cycle();
        end
        for (int n = 0; n < exp_tx.size(); n++) begin
            check_bit(tx_active, 1'b1, "tx_active during program");
            check_level(tx, exp_tx[n], "tx level");
            if (r.stop_after != 0 && n == exp_tx.size() - 1) begin
                bus.write = 1'b1;
                bus.addr  = pulse_cfg_pkg::addr_t'(pulse_cfg_pkg::REG_CTRL_ADDR);
                bus.wdata = ctrl_word(r.cfg) | (32'd1 << pulse_cfg_pkg::CTRL_STOP_BIT);
            end
            step_cycle();
            bus.write = 1'b0;
        end
        check_bit(tx_active, 1'b0, "tx_active after program");
        check_level(tx, idle_tx, "idle tx after program");
        if (r.stop_after != 0) begin
            check_bit(rdata[4], 1'b0, "running after stop");
        end else begin
            // Running still high in the done cycle, so status is not reloaded yet
            check_index(rdata[14:8], r.cfg.end_index, "index at end");
            check_loop(rdata[23:16], loops_end, "loop counter at end");
            step_cycle();
            check_bit(rdata[4], 1'b0, "running after end");
            check_flags(rdata[1:0], r.exp_flags, "flags after end");
            check_bit(irq, |r.exp_flags, "irq after end");
            check_level(tx, idle_tx, "idle tx after end");
            if (|r.exp_flags) begin
                write_reg(pulse_cfg_pkg::REG_CTRL_ADDR, ctrl_word(r.cfg) | r.exp_flags);
                check_flags(rdata[1:0], 2'b00, "flags after write-1 clear");
                check_bit(irq, 1'b0, "irq after write-1 clear");
            end
        end
    endtask

    initial begin
        pulse_cfg_pkg::loop_count_t unused_loops;
        int unsigned                total;
        bus         = '0;
        cycle_count = 0;
        cycle_limit = 0;
        error_count = 0;
        seed_value  = $urandom(88);
        // start end back loops forever down idle inv irq_en durations presc stop flags
        rows[0] = make_row(7'd3, 7'd12, 7'd0, 8'd0, 1'b0, 1'b0, 1'b0, 1'b0, 2'b00,
                           32'h01_07_02_05, 4'd0, 0, 2'b00);
        rows[1] = make_row(7'd20, 7'd25, 7'd22, 8'd2, 1'b0, 1'b0, 1'b0, 1'b0, 2'b11,
                           32'h03_00_01_04, 4'd0, 0, 2'b11);
        rows[2] = make_row(7'd4, 7'd122, 7'd0, 8'd0, 1'b0, 1'b1, 1'b0, 1'b0, 2'b00,
                           32'h02_01_03_00, 4'd2, 0, 2'b00);
        rows[3] = make_row(7'd64, 7'd71, 7'd0, 8'd0, 1'b0, 1'b0, 1'b1, 1'b0, 2'b10,
                           32'h04_02_06_01, 4'd0, 0, 2'b10);
        rows[4] = make_row(7'd100, 7'd110, 7'd0, 8'd0, 1'b0, 1'b0, 1'b0, 1'b1, 2'b00,
                           32'h00_05_01_03, 4'd1, 0, 2'b00);
        rows[5] = make_row(7'd8, 7'd15, 7'd10, 8'd0, 1'b1, 1'b0, 1'b1, 1'b1, 2'b00,
                           32'h02_03_01_04, 4'd0, 150, 2'b00);
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            build_expected(rows[i], unused_loops);
            total += exp_tx.size() + ROW_MARGIN;
        end
        cycle_limit = total;
        wait (rst_n === 1'b1);
        // Reset state
        check_bit(tx_active, 1'b0, "tx_active after reset");
        check_bit(irq, 1'b0, "irq after reset");
        check_bit(rdata[4], 1'b0, "running after reset");
        check_flags(rdata[1:0], 2'b00, "flags after reset");
        check_level(tx, 1'b0, "tx after reset");
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        if (error_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

/* all.f */
hdl/pulse_sym_pkg.sv
hdl/pulse_cfg_pkg.sv
hdl/pulse_regs.sv
hdl/pulse_sequencer.sv
hdl/pulse_symbol_decode.sv
hdl/pulse_timer.sv
hdl/pulse_transmitter.sv
tb/clk_gen.sv
tb/tb_pulse_transmitter.sv

/* Bender.yml */
package:
  name: pulse_transmitter

sources:
  - hdl/pulse_sym_pkg.sv
  - hdl/pulse_cfg_pkg.sv
  - hdl/pulse_regs.sv
  - hdl/pulse_sequencer.sv
  - hdl/pulse_symbol_decode.sv
  - hdl/pulse_timer.sv
  - hdl/pulse_transmitter.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/tb_pulse_transmitter.sv
